// ==== common/ddr4_mon_macros.svh ====
`ifndef DDR4_MON_MACROS_SVH
`define DDR4_MON_MACROS_SVH

// Command/address bus widths
`define DDR4_ADR_W      17
`define DDR4_BA_W       2
`define DDR4_BG_W       2
`define DDR4_RANKS      2
`define DDR4_CA_MIRROR  1

// Column commands carry no address on A13:A11
`define DDR4_COL_MASK   17'h1C7FF

`define DDR4_CNT_W      16
`define WB_ADR_W        4
`define WB_DAT_W        32

// Opcodes on A16:A14 (RAS_n, CAS_n, WE_n) with act_n high
`define DDR4_OP_MRS     3'b000
`define DDR4_OP_REF     3'b001
`define DDR4_OP_PRE     3'b010
`define DDR4_OP_WR      3'b100
`define DDR4_OP_RD      3'b101
`define DDR4_OP_ZQC     3'b110
`define DDR4_OP_NOP     3'b111

// Register map, word offsets
`define REG_CTRL        4'h0
`define REG_ACT         4'h1
`define REG_WR          4'h2
`define REG_RD          4'h3
`define REG_REF         4'h4
`define REG_PRE         4'h5
`define REG_ILL         4'h6
`define REG_LAST        4'h7
`define REG_STAT        4'h8

`endif

// ==== common/ddr4_mon_pkg.sv ====
`include "ddr4_mon_macros.svh"

package ddr4_mon_pkg;

    // ======================================================================
    // Command bus fields
    // ======================================================================

    typedef logic [`DDR4_ADR_W-1:0] ddr4_adr_t;
    typedef logic [`DDR4_BA_W-1:0]  ddr4_ba_t;
    typedef logic [`DDR4_BG_W-1:0]  ddr4_bg_t;

    // One active-low select per rank
    typedef logic [`DDR4_RANKS-1:0] ddr4_cs_t;

    // ======================================================================
    // Monitor and register side
    // ======================================================================

    typedef logic [`DDR4_CNT_W-1:0] mon_cnt_t;
    typedef logic [`WB_ADR_W-1:0]   wb_adr_t;
    typedef logic [`WB_DAT_W-1:0]   wb_data_t;

    // Decoded command
    typedef enum logic [3:0] {
        CMD_DSEL,
        CMD_ACT,
        CMD_MRS,
        CMD_REF,
        CMD_PRE,
        CMD_WR,
        CMD_RD,
        CMD_ZQC,
        CMD_NOP,
        CMD_ILL
    } ddr4_cmd_e;

endpackage

// ==== ca_decode/ddr4_cmd_decoder.sv ====
`timescale 1ns/1ps
`include "ddr4_mon_macros.svh"

module ddr4_cmd_decoder
    import ddr4_mon_pkg::*;
(
    input  logic      c0_ddr4_ck_t,
    input  logic      rst_n,
    input  ddr4_cs_t  cs_n,
    input  logic      act_n,
    input  ddr4_adr_t adr,
    input  ddr4_ba_t  ba,
    input  ddr4_bg_t  bg,
    output logic      cmd_valid,
    output ddr4_cmd_e cmd,
    output logic      cmd_rank,
    output ddr4_adr_t cmd_adr,
    output ddr4_ba_t  cmd_ba,
    output ddr4_bg_t  cmd_bg
);

    localparam bit MIRROR_EN = (`DDR4_CA_MIRROR != 0);

    ddr4_cs_t  cs_q;
    logic      act_q;
    ddr4_adr_t adr_q;
    ddr4_ba_t  ba_q;
    ddr4_bg_t  bg_q;

    logic      rank_d;
    ddr4_adr_t adr_u;
    ddr4_ba_t  ba_u;
    ddr4_bg_t  bg_u;
    ddr4_cmd_e cmd_d;

    // ======================================================================
    // Bus sampling
    // ======================================================================

    // Idle bus after reset is a deselect
    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            cs_q  <= '1;
            act_q <= 1'b1;
        end else begin
            cs_q  <= cs_n;
            act_q <= act_n;
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        adr_q <= adr;
        ba_q  <= ba;
        bg_q  <= bg;
    end

    // ======================================================================
    // Rank select and clamshell unmirroring
    // ======================================================================

    // Rank 0 wins when both selects are low
    assign rank_d = cs_q[0];

    always_comb begin
        if (MIRROR_EN && rank_d) begin
            adr_u = {adr_q[16:14],
                     adr_q[11], adr_q[12], adr_q[13],
                     adr_q[10:9],
                     adr_q[7], adr_q[8],
                     adr_q[5], adr_q[6],
                     adr_q[3], adr_q[4],
                     adr_q[2:0]};
            ba_u  = {ba_q[0], ba_q[1]};
            bg_u  = {bg_q[0], bg_q[1]};
        end else begin
            adr_u = adr_q;
            ba_u  = ba_q;
            bg_u  = bg_q;
        end
    end

    // ======================================================================
    // Command decode
    // ======================================================================

    // A16:A14 are outside the mirrored pairs
    always_comb begin
        if (&cs_q) begin
            cmd_d = CMD_DSEL;
        end else if (!act_q) begin
            cmd_d = CMD_ACT;
        end else begin
            case (adr_q[16:14])
                `DDR4_OP_MRS: cmd_d = CMD_MRS;
                `DDR4_OP_REF: cmd_d = CMD_REF;
                `DDR4_OP_PRE: cmd_d = CMD_PRE;
                `DDR4_OP_WR:  cmd_d = CMD_WR;
                `DDR4_OP_RD:  cmd_d = CMD_RD;
                `DDR4_OP_ZQC: cmd_d = CMD_ZQC;
                `DDR4_OP_NOP: cmd_d = CMD_NOP;
                default:      cmd_d = CMD_ILL;
            endcase
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= (cmd_d != CMD_DSEL);
        end
    end

    // Column address bits A13:A11 dropped for WR and RD
    always_ff @(posedge c0_ddr4_ck_t) begin
        cmd      <= cmd_d;
        cmd_rank <= rank_d;
        cmd_ba   <= ba_u;
        cmd_bg   <= bg_u;
        if (cmd_d == CMD_WR || cmd_d == CMD_RD) begin
            cmd_adr <= adr_u & `DDR4_COL_MASK;
        end else begin
            cmd_adr <= adr_u;
        end
    end

endmodule

// ==== hdl/ddr4_cmd_counters.sv ====
`timescale 1ns/1ps

module ddr4_cmd_counters
    import ddr4_mon_pkg::*;
(
    input  logic      c0_ddr4_ck_t,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  ddr4_cmd_e cmd,
    input  logic      cmd_rank,
    input  ddr4_adr_t cmd_adr,
    input  ddr4_ba_t  cmd_ba,
    input  ddr4_bg_t  cmd_bg,
    input  logic      clear,
    input  logic      count_en,
    output mon_cnt_t  cnt_act,
    output mon_cnt_t  cnt_wr,
    output mon_cnt_t  cnt_rd,
    output mon_cnt_t  cnt_ref,
    output mon_cnt_t  cnt_pre,
    output mon_cnt_t  cnt_ill,
    output wb_data_t  last_info,
    output logic      dir_write
);

    // Holds at all ones
    function automatic mon_cnt_t sat_inc(input mon_cnt_t val);
        return (&val) ? val : val + 1'b1;
    endfunction

    // ======================================================================
    // Command counters
    // ======================================================================

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n || clear) begin
            cnt_act <= '0;
            cnt_wr  <= '0;
            cnt_rd  <= '0;
            cnt_ref <= '0;
            cnt_pre <= '0;
            cnt_ill <= '0;
        end else if (cmd_valid && count_en) begin
            // MRS, ZQC and NOP are not counted
            case (cmd)
                CMD_ACT: cnt_act <= sat_inc(cnt_act);
                CMD_WR:  cnt_wr  <= sat_inc(cnt_wr);
                CMD_RD:  cnt_rd  <= sat_inc(cnt_rd);
                CMD_REF: cnt_ref <= sat_inc(cnt_ref);
                CMD_PRE: cnt_pre <= sat_inc(cnt_pre);
                CMD_ILL: cnt_ill <= sat_inc(cnt_ill);
                default: ;
            endcase
        end
    end

    // ======================================================================
    // Last command capture and bus direction
    // ======================================================================

    // Layout {rank, bg, ba, adr}, zero-extended
    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n || clear) begin
            last_info <= '0;
        end else if (cmd_valid) begin
            last_info <= wb_data_t'({cmd_rank, cmd_bg, cmd_ba, cmd_adr});
        end
    end

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            dir_write <= 1'b0;
        end else if (cmd_valid && cmd == CMD_WR) begin
            dir_write <= 1'b1;
        end else if (cmd_valid && cmd == CMD_RD) begin
            dir_write <= 1'b0;
        end
    end

endmodule

// ==== hdl/ddr4_mon_wb_regs.sv ====
`timescale 1ns/1ps
`include "ddr4_mon_macros.svh"

module ddr4_mon_wb_regs
    import ddr4_mon_pkg::*;
(
    input  logic     c0_ddr4_ck_t,
    input  logic     rst_n,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_adr_t  wb_adr,
    input  wb_data_t wb_dat_w,
    input  mon_cnt_t cnt_act,
    input  mon_cnt_t cnt_wr,
    input  mon_cnt_t cnt_rd,
    input  mon_cnt_t cnt_ref,
    input  mon_cnt_t cnt_pre,
    input  mon_cnt_t cnt_ill,
    input  wb_data_t last_info,
    input  logic     dir_write,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    output logic     clear,
    output logic     count_en
);

    logic     wb_req;
    wb_data_t rd_data;

    // New cycle seen, ack not yet given
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;

    // ======================================================================
    // Handshake and control register
    // ======================================================================

    always_ff @(posedge c0_ddr4_ck_t) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            clear    <= 1'b0;
            count_en <= 1'b1;
        end else begin
            wb_ack <= wb_req;
            clear  <= 1'b0;
            if (wb_req && wb_we && wb_adr == `REG_CTRL) begin
                clear    <= wb_dat_w[0];
                count_en <= wb_dat_w[1];
            end
        end
    end

    // ======================================================================
    // Read data
    // ======================================================================

    always_comb begin
        case (wb_adr)
            `REG_CTRL: rd_data = wb_data_t'({count_en, 1'b0});
            `REG_ACT:  rd_data = wb_data_t'(cnt_act);
            `REG_WR:   rd_data = wb_data_t'(cnt_wr);
            `REG_RD:   rd_data = wb_data_t'(cnt_rd);
            `REG_REF:  rd_data = wb_data_t'(cnt_ref);
            `REG_PRE:  rd_data = wb_data_t'(cnt_pre);
            `REG_ILL:  rd_data = wb_data_t'(cnt_ill);
            `REG_LAST: rd_data = last_info;
            `REG_STAT: rd_data = wb_data_t'(dir_write);
            default:   rd_data = '0;
        endcase
    end

    // Captured with the rising ack
    always_ff @(posedge c0_ddr4_ck_t) begin
        if (wb_req) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

// ==== hdl/ddr4_cmd_monitor.sv ====
`timescale 1ns/1ps

module ddr4_cmd_monitor
    import ddr4_mon_pkg::*;
(
    input  logic      c0_ddr4_ck_t,
    input  logic      rst_n,
    input  ddr4_cs_t  cs_n,
    input  logic      act_n,
    input  ddr4_adr_t adr,
    input  ddr4_ba_t  ba,
    input  ddr4_bg_t  bg,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_adr_t   wb_adr,
    input  wb_data_t  wb_dat_w,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack
);

    // Decoded command stream
    logic      cmd_valid;
    ddr4_cmd_e cmd;
    logic      cmd_rank;
    ddr4_adr_t cmd_adr;
    ddr4_ba_t  cmd_ba;
    ddr4_bg_t  cmd_bg;

    // Status toward the register slave
    mon_cnt_t  cnt_act;
    mon_cnt_t  cnt_wr;
    mon_cnt_t  cnt_rd;
    mon_cnt_t  cnt_ref;
    mon_cnt_t  cnt_pre;
    mon_cnt_t  cnt_ill;
    wb_data_t  last_info;
    logic      dir_write;

    // Control back to the counters
    logic      clear;
    logic      count_en;

    ddr4_cmd_decoder u_decoder (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cs_n         (cs_n),
        .act_n        (act_n),
        .adr          (adr),
        .ba           (ba),
        .bg           (bg),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_rank     (cmd_rank),
        .cmd_adr      (cmd_adr),
        .cmd_ba       (cmd_ba),
        .cmd_bg       (cmd_bg)
    );

    ddr4_cmd_counters u_counters (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_rank     (cmd_rank),
        .cmd_adr      (cmd_adr),
        .cmd_ba       (cmd_ba),
        .cmd_bg       (cmd_bg),
        .clear        (clear),
        .count_en     (count_en),
        .cnt_act      (cnt_act),
        .cnt_wr       (cnt_wr),
        .cnt_rd       (cnt_rd),
        .cnt_ref      (cnt_ref),
        .cnt_pre      (cnt_pre),
        .cnt_ill      (cnt_ill),
        .last_info    (last_info),
        .dir_write    (dir_write)
    );

    ddr4_mon_wb_regs u_wb_regs (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .cnt_act      (cnt_act),
        .cnt_wr       (cnt_wr),
        .cnt_rd       (cnt_rd),
        .cnt_ref      (cnt_ref),
        .cnt_pre      (cnt_pre),
        .cnt_ill      (cnt_ill),
        .last_info    (last_info),
        .dir_write    (dir_write),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .clear        (clear),
        .count_en     (count_en)
    );

endmodule

// ==== bench/ddr4_cmd_monitor_chk.sv ====
`timescale 1ns/1ps

module ddr4_cmd_monitor_chk (
    input logic c0_ddr4_ck_t,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    int err_cnt = 0;

    // ======================================================================
    // Wishbone handshake
    // ======================================================================

    // Single-cycle ack
    ack_one_cycle: assert property (
        @(posedge c0_ddr4_ck_t) disable iff (!rst_n)
        wb_ack |=> !wb_ack
    ) else begin
        $error("wb_ack held for two cycles");
        err_cnt++;
    end

    // Ack only after a request
    ack_after_req: assert property (
        @(posedge c0_ddr4_ck_t) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb)
    ) else begin
        $error("wb_ack without a preceding cyc and stb");
        err_cnt++;
    end

    ack_low_in_reset: assert property (
        @(posedge c0_ddr4_ck_t)
        !rst_n |=> !wb_ack
    ) else begin
        $error("wb_ack high during reset");
        err_cnt++;
    end

endmodule

bind ddr4_cmd_monitor ddr4_cmd_monitor_chk u_chk (
    .c0_ddr4_ck_t (c0_ddr4_ck_t),
    .rst_n        (rst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack)
);

// ==== bench/ddr4_cmd_monitor_tb.sv ====
`timescale 1ns/1ps

module ddr4_cmd_monitor_tb
    import ddr4_mon_pkg::*;
();

    logic      c0_ddr4_ck_t;
    logic      rst_n;
    ddr4_cs_t  cs_n;
    logic      act_n;
    ddr4_adr_t adr;
    ddr4_ba_t  ba;
    ddr4_bg_t  bg;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_adr_t   wb_adr;
    wb_data_t  wb_dat_w;
    wb_data_t  wb_dat_r;
    logic      wb_ack;

    // Parsed pattern operations
    byte         op_kind[$];
    string       op_name[$];
    logic [31:0] op_f0[$];
    logic [31:0] op_f1[$];
    logic [31:0] op_f2[$];
    logic [31:0] op_f3[$];
    logic [31:0] op_f4[$];

    int pass_cnt = 0;
    int fail_cnt = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    ddr4_cmd_monitor dut (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .rst_n        (rst_n),
        .cs_n         (cs_n),
        .act_n        (act_n),
        .adr          (adr),
        .ba           (ba),
        .bg           (bg),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    initial begin
        c0_ddr4_ck_t = 1'b0;
        forever #2 c0_ddr4_ck_t = ~c0_ddr4_ck_t;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic load_patterns();
        int    fd;
        int    n;
        byte   kind;
        string line;
        string name;
        logic [31:0] f0, f1, f2, f3, f4;
        fd = $fopen("bench/ddr4_cmd_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open pattern file bench/ddr4_cmd_patterns.txt");
            fail_cnt++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            // Blank lines and comments
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            kind = line[0];
            name = "";
            f2 = '0;
            f3 = '0;
            f4 = '0;
            if (kind == "C") begin
                n = $sscanf(line, "%c %h %h %h %h %h", kind, f0, f1, f2, f3, f4);
                n = (n == 6) ? 1 : 0;
            end else if (kind == "W") begin
                n = $sscanf(line, "%c %h %h", kind, f0, f1);
                n = (n == 3) ? 1 : 0;
            end else if (kind == "R") begin
                n = $sscanf(line, "%c %s %h %h", kind, name, f0, f1);
                n = (n == 4) ? 1 : 0;
            end else begin
                n = 0;
            end
            if (n == 0) begin
                $display("Malformed pattern line: %s", line);
                fail_cnt++;
            end else begin
                op_kind.push_back(kind);
                op_name.push_back(name);
                op_f0.push_back(f0);
                op_f1.push_back(f1);
                op_f2.push_back(f2);
                op_f3.push_back(f3);
                op_f4.push_back(f4);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        cs_n  = '1;
        act_n = 1'b1;
        adr   = '0;
        ba    = '0;
        bg    = '0;
    endtask

    // One command held for a single clock
    task automatic bus_command(input logic [31:0] c, input logic [31:0] a_n,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] g);
        @(negedge c0_ddr4_ck_t);
        cs_n  = ddr4_cs_t'(c);
        act_n = a_n[0];
        adr   = ddr4_adr_t'(a);
        ba    = ddr4_ba_t'(b);
        bg    = ddr4_bg_t'(g);
    endtask

    task automatic wb_transfer(input logic we, input wb_adr_t offset, input wb_data_t wdata,
                               output wb_data_t rdata, output bit acked);
        int waited;
        @(negedge c0_ddr4_ck_t);
        drive_idle();
        // Let the last command reach the registers
        repeat (2) @(negedge c0_ddr4_ck_t);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = offset;
        wb_dat_w = wdata;
        waited = 0;
        acked  = 1'b0;
        rdata  = '0;
        while (!acked && waited < 8) begin
            @(negedge c0_ddr4_ck_t);
            waited++;
            if (wb_ack) begin
                acked = 1'b1;
                rdata = wb_dat_r;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!acked) begin
            $display("Wishbone access to offset %0d got no acknowledge within 8 cycles",
                     offset);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        int       idx;
        wb_data_t rdata;
        bit       acked;
        bit       ok;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        drive_idle();
        load_patterns();
        if (op_kind.size() == 0) begin
            $display("No usable pattern lines were found");
            fail_cnt++;
        end
        cycle_limit = op_kind.size() * 10 + 100;
        repeat (5) @(posedge c0_ddr4_ck_t);
        @(negedge c0_ddr4_ck_t);
        rst_n = 1'b1;

        for (idx = 0; idx < op_kind.size(); idx++) begin
            case (op_kind[idx])
                "C": begin
                    bus_command(op_f0[idx], op_f1[idx], op_f2[idx], op_f3[idx], op_f4[idx]);
                end
                "W": begin
                    wb_transfer(1'b1, wb_adr_t'(op_f0[idx]), op_f1[idx], rdata, acked);
                    if (!acked) begin
                        fail_cnt++;
                    end
                end
                default: begin
                    wb_transfer(1'b0, wb_adr_t'(op_f0[idx]), '0, rdata, acked);
                    if (!acked) begin
                        $display("Test %s failed, register read was not acknowledged",
                                 op_name[idx]);
                        fail_cnt++;
                    end else begin
                        check_value(op_name[idx], op_f1[idx], rdata, ok);
                        if (ok) begin
                            $display("Test %s passed", op_name[idx]);
                            pass_cnt++;
                        end else begin
                            $display("Test %s failed", op_name[idx]);
                            fail_cnt++;
                        end
                    end
                end
            endcase
        end

        @(negedge c0_ddr4_ck_t);
        if (dut.u_chk.err_cnt != 0) begin
            $display("Wishbone handshake assertions failed %0d times", dut.u_chk.err_cnt);
            fail_cnt += dut.u_chk.err_cnt;
        end
        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog armed once the patterns set the cycle limit
    initial begin
        while (cycle_limit == 0 || cycle_cnt < cycle_limit) begin
            @(posedge c0_ddr4_ck_t);
            cycle_cnt++;
        end
        $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== bench/ddr4_cmd_patterns.txt ====
# C cs_n act_n adr ba bg : bus command, all fields hex
# W offset data : register write ; R name offset expected : register read and compare
# Each command once on rank 0, DSEL NOP MRS ZQC are not counted
C 2 0 00123 1 2
C 2 1 10040 0 0
C 2 1 14080 0 0
C 2 1 04000 0 0
C 2 1 08000 0 0
C 3 0 00000 0 0
C 2 1 1C000 0 0
C 2 1 00000 0 0
C 2 1 18000 0 0
R act_one 1 00000001
R wr_one 2 00000001
R rd_one 3 00000001
R ref_one 4 00000001
R pre_one 5 00000001
R ill_none 6 00000000
R last_zqc 7 00018000
# Reserved opcode
C 2 1 0C000 0 0
R ill_one 6 00000001
# Direction flag
C 2 1 10000 0 0
R dir_after_wr 8 00000001
C 2 0 00055 0 0
R dir_after_act 8 00000001
C 2 1 14000 0 0
R dir_after_rd 8 00000000
# Rank 1 unmirroring, then rank 0 column mask
C 1 1 10808 1 2
R last_r1_wr 7 002D0010
C 1 0 108A2 2 1
R last_r1_act 7 00332142
C 2 1 13923 3 1
R last_r0_wr 7 000F0123
R act_total 1 00000003
R wr_total 2 00000004
R rd_total 3 00000002
# Clear, then counting disabled
W 0 00000003
R ctrl_after_clear 0 00000002
R act_cleared 1 00000000
R wr_cleared 2 00000000
R rd_cleared 3 00000000
R ref_cleared 4 00000000
R pre_cleared 5 00000000
R ill_cleared 6 00000000
R last_cleared 7 00000000
W 0 00000000
R ctrl_disabled 0 00000000
C 2 0 00321 2 1
C 2 1 10444 0 0
R act_disabled 1 00000000
R wr_disabled 2 00000000
R last_disabled 7 00010444
C 2 1 14000 0 0
R rd_disabled 3 00000000
R dir_disabled 8 00000000

// ==== ddr4_cmd_monitor.f ====
+incdir+common
common/ddr4_mon_pkg.sv
ca_decode/ddr4_cmd_decoder.sv
hdl/ddr4_cmd_counters.sv
hdl/ddr4_mon_wb_regs.sv
hdl/ddr4_cmd_monitor.sv
bench/ddr4_cmd_monitor_chk.sv
bench/ddr4_cmd_monitor_tb.sv

// ==== Bender.yml ====
package:
  name: ddr4_cmd_monitor

sources:
  - include_dirs:
      - common
    files:
      - common/ddr4_mon_pkg.sv
      - ca_decode/ddr4_cmd_decoder.sv
      - hdl/ddr4_cmd_counters.sv
      - hdl/ddr4_mon_wb_regs.sv
      - hdl/ddr4_cmd_monitor.sv
  - target: simulation
    files:
      - bench/ddr4_cmd_monitor_chk.sv
      - bench/ddr4_cmd_monitor_tb.sv
